// File: source/seq_pkg.sv
package seq_pkg;

   // Word widths of the sequencer.
   localparam int INST_W  = 20;
   localparam int ADDR_W  = 8;
   localparam int WORD_W  = 12;
   localparam int DATA_W  = 8;
   localparam int NUM_DEV = 8;   // Write-enable lines.

   typedef logic [INST_W-1:0] inst_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [3:0]        op_t;
   typedef logic [1:0]        sel_t;

   // Opcodes.
   localparam op_t OP_NOP = 4'h0;
   localparam op_t OP_JMP = 4'h1;
   localparam op_t OP_JNZ = 4'h2;   // Jump if selected input register is nonzero.
   localparam op_t OP_WRI = 4'h3;   // Write immediate word.
   localparam op_t OP_WRR = 4'h4;   // Write upper nibble plus input register.

   // Field positions in the instruction word.
   localparam int OP_MSB   = 19;
   localparam int OP_LSB   = 16;
   localparam int DEV_MSB  = 14;
   localparam int DEV_LSB  = 12;
   localparam int IMM_MSB  = 11;
   localparam int IMM_LSB  = 0;
   localparam int HDR_LSB  = 8;     // Low end of the nibble kept by WRR.
   localparam int JSEL_MSB = 9;
   localparam int JSEL_LSB = 8;
   localparam int TGT_MSB  = 7;
   localparam int TGT_LSB  = 0;
   localparam int RSEL_MSB = 1;
   localparam int RSEL_LSB = 0;

   // Input register selects; select 3 reads zero.
   localparam sel_t IREG_ALU   = 2'd0;
   localparam sel_t IREG_LEFT  = 2'd1;
   localparam sel_t IREG_RIGHT = 2'd2;

endpackage

// File: source/dev_pkg.sv
package dev_pkg;

   typedef logic [3:0] subop_t;
   typedef logic [2:0] dev_idx_t;

   // Sub-op and immediate fields of the output word.
   localparam int SUBOP_MSB = 11;
   localparam int SUBOP_LSB = 8;
   localparam int IMM_MSB   = 7;
   localparam int IMM_LSB   = 0;

   // Peripheral indices, one write-enable bit each.
   localparam dev_idx_t DEV_ALU = 3'd0;
   localparam dev_idx_t DEV_ROT = 3'd1;
   localparam dev_idx_t DEV_LED = 3'd2;

   // Accumulator.
   localparam subop_t ALU_LOAD = 4'h0;
   localparam subop_t ALU_ROL  = 4'h1;
   localparam subop_t ALU_ROR  = 4'h2;

   // Rotary decoder.
   localparam subop_t ROT_CLEAR = 4'h0;

   // LED bank.
   localparam subop_t LED_LOAD       = 4'h0;
   localparam subop_t LED_LOAD_BLINK = 4'h1;

   // Blink half period is 2**BLINK_LOG2 cycles.
   localparam int BLINK_LOG2 = 3;

endpackage

// File: source/code_rom.sv
module code_rom (
   input  seq_pkg::addr_t addr,
   output seq_pkg::inst_t data
);

   function automatic seq_pkg::inst_t f_op(input seq_pkg::op_t op);
      seq_pkg::inst_t w;
      w = '0;
      w[seq_pkg::OP_MSB:seq_pkg::OP_LSB] = op;
      return w;
   endfunction

   function automatic seq_pkg::inst_t f_jmp(input seq_pkg::addr_t tgt);
      seq_pkg::inst_t w;
      w = f_op(seq_pkg::OP_JMP);
      w[seq_pkg::TGT_MSB:seq_pkg::TGT_LSB] = tgt;
      return w;
   endfunction

   function automatic seq_pkg::inst_t f_jnz(input seq_pkg::sel_t sel,
                                            input seq_pkg::addr_t tgt);
      seq_pkg::inst_t w;
      w = f_jmp(tgt);
      w[seq_pkg::OP_MSB:seq_pkg::OP_LSB]     = seq_pkg::OP_JNZ;
      w[seq_pkg::JSEL_MSB:seq_pkg::JSEL_LSB] = sel;
      return w;
   endfunction

   // Write with sub-op and low byte; for WRR the low byte holds the register select.
   function automatic seq_pkg::inst_t f_wr(input seq_pkg::op_t     op,
                                           input dev_pkg::dev_idx_t dev,
                                           input dev_pkg::subop_t   sub,
                                           input seq_pkg::data_t    low);
      seq_pkg::inst_t w;
      w = f_op(op);
      w[seq_pkg::DEV_MSB:seq_pkg::DEV_LSB] = dev;
      w[seq_pkg::IMM_MSB:seq_pkg::IMM_LSB] = {sub, low};
      return w;
   endfunction

   always_comb begin
      case (addr)
         8'd0:  data = f_wr(seq_pkg::OP_WRI, dev_pkg::DEV_LED, dev_pkg::LED_LOAD_BLINK, 8'h01);
         8'd1:  data = f_wr(seq_pkg::OP_WRI, dev_pkg::DEV_ALU, dev_pkg::ALU_LOAD, 8'h01);
         8'd2:  data = f_wr(seq_pkg::OP_WRI, dev_pkg::DEV_ROT, dev_pkg::ROT_CLEAR, 8'h00);
         8'd3:  data = f_op(seq_pkg::OP_NOP);   // Let the clear land.
         8'd4:  data = f_jnz(seq_pkg::IREG_LEFT, 8'd8);
         8'd5:  data = f_jnz(seq_pkg::IREG_RIGHT, 8'd12);
         8'd6:  data = f_jmp(8'd4);
         8'd8:  data = f_wr(seq_pkg::OP_WRI, dev_pkg::DEV_ALU, dev_pkg::ALU_ROL, 8'h00);
         8'd9:  data = f_jmp(8'd13);
         8'd12: data = f_wr(seq_pkg::OP_WRI, dev_pkg::DEV_ALU, dev_pkg::ALU_ROR, 8'h00);
         8'd13: data = f_wr(seq_pkg::OP_WRI, dev_pkg::DEV_ROT, dev_pkg::ROT_CLEAR, 8'h00);
         8'd14: data = f_op(seq_pkg::OP_NOP);
         8'd15: data = f_wr(seq_pkg::OP_WRR, dev_pkg::DEV_LED, dev_pkg::LED_LOAD,
                            seq_pkg::data_t'(seq_pkg::IREG_ALU));
         8'd16: data = f_jmp(8'd4);
         default: data = f_jmp(8'd4);
      endcase
   end

endmodule

// File: source/alu.sv
module alu (
   input  logic           clock,
   input  logic           rst_n,
   input  seq_pkg::word_t inst,
   input  logic           inst_en,
   output seq_pkg::data_t result
);

   dev_pkg::subop_t subop;
   seq_pkg::data_t  imm;
   seq_pkg::data_t  acc;

   assign subop = inst[dev_pkg::SUBOP_MSB:dev_pkg::SUBOP_LSB];
   assign imm   = inst[dev_pkg::IMM_MSB:dev_pkg::IMM_LSB];

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (inst_en) begin
         case (subop)
            dev_pkg::ALU_LOAD: acc <= imm;
            dev_pkg::ALU_ROL:  acc <= {acc[6:0], acc[7]};
            dev_pkg::ALU_ROR:  acc <= {acc[0], acc[7:1]};
            default:           acc <= acc;   // Unknown sub-op is ignored.
         endcase
      end
   end

   assign result = acc;

   // A floating enable would corrupt the accumulator silently.
   a_en_known: assert property (
      @(posedge clock) disable iff (!rst_n)
      !$isunknown(inst_en)
   ) else $error("alu inst_en is unknown");

endmodule

// File: source/rotary_decoder.sv
module rotary_decoder (
   input  logic           clock,
   input  logic           rst_n,
   input  seq_pkg::word_t inst,
   input  logic           inst_en,
   input  logic [1:0]     rotary,
   output logic           left_status,
   output logic           right_status
);

   logic [1:0] a_sync;   // Two-flop synchronizer, channel a.
   logic [1:0] b_sync;
   logic       a_prev;
   logic       a_rise;
   logic       set_left;
   logic       set_right;
   logic       clear;

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         a_sync <= '0;
         b_sync <= '0;
         a_prev <= 1'b0;
      end else begin
         a_sync <= {a_sync[0], rotary[0]};
         b_sync <= {b_sync[0], rotary[1]};
         a_prev <= a_sync[1];
      end
   end

   assign a_rise    = a_sync[1] & ~a_prev;
   assign set_left  = a_rise & b_sync[1];    // b leads a.
   assign set_right = a_rise & ~b_sync[1];
   assign clear     = inst_en &&
                      (inst[dev_pkg::SUBOP_MSB:dev_pkg::SUBOP_LSB] == dev_pkg::ROT_CLEAR);

   // A set wins over a clear in the same cycle.
   always_ff @(posedge clock) begin
      if (!rst_n) begin
         left_status  <= 1'b0;
         right_status <= 1'b0;
      end else begin
         left_status  <= set_left | (left_status & ~clear);
         right_status <= set_right | (right_status & ~clear);
      end
   end

   // One detent raises one direction only.
   a_one_dir: assert property (
      @(posedge clock) disable iff (!rst_n)
      !($rose(left_status) && $rose(right_status))
   ) else $error("left and right flags set by the same edge");

   // A flag only rises three cycles after channel a went high at the port.
   a_rise_latency: assert property (
      @(posedge clock) disable iff (!rst_n)
      ($rose(left_status) || $rose(right_status)) |-> $past(rotary[0], 3)
   ) else $error("rotary flag set without a prior edge on channel a");

endmodule

// File: source/led_bank.sv
module led_bank (
   input  logic           clock,
   input  logic           rst_n,
   input  seq_pkg::word_t inst,
   input  logic           inst_en,
   output logic [7:0]     leds
);

   dev_pkg::subop_t              subop;
   logic [7:0]                   led_val;
   logic                         blink;
   logic [dev_pkg::BLINK_LOG2:0] blink_cnt;   // Top bit picks the dark half.

   assign subop = inst[dev_pkg::SUBOP_MSB:dev_pkg::SUBOP_LSB];

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         led_val   <= '0;
         blink     <= 1'b0;
         blink_cnt <= '0;
      end else begin
         blink_cnt <= blink_cnt + 1'b1;
         if (inst_en) begin
            case (subop)
               dev_pkg::LED_LOAD: begin
                  led_val <= inst[dev_pkg::IMM_MSB:dev_pkg::IMM_LSB];
                  blink   <= 1'b0;
               end
               dev_pkg::LED_LOAD_BLINK: begin
                  led_val <= inst[dev_pkg::IMM_MSB:dev_pkg::IMM_LSB];
                  blink   <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   assign leds = (blink && blink_cnt[dev_pkg::BLINK_LOG2]) ? 8'h00 : led_val;

endmodule

// File: source/sequencer.sv
module sequencer (
   input  logic                        clock,
   input  logic                        rst_n,
   input  seq_pkg::inst_t              inst,
   input  seq_pkg::data_t              ireg_0,
   input  seq_pkg::data_t              ireg_1,
   input  seq_pkg::data_t              ireg_2,
   output seq_pkg::addr_t              next,
   output seq_pkg::word_t              oreg,
   output logic [seq_pkg::NUM_DEV-1:0] oreg_wen
);

   seq_pkg::op_t                op;
   seq_pkg::addr_t              target;
   seq_pkg::data_t              jnz_val;
   seq_pkg::data_t              wrr_val;
   dev_pkg::dev_idx_t           dev;
   logic [seq_pkg::NUM_DEV-1:0] dev_onehot;
   seq_pkg::word_t              word;
   logic                        take_jump;
   logic                        is_write;

   function automatic seq_pkg::data_t read_ireg(
      input seq_pkg::sel_t  sel,
      input seq_pkg::data_t r0,
      input seq_pkg::data_t r1,
      input seq_pkg::data_t r2
   );
      seq_pkg::data_t val;
      case (sel)
         seq_pkg::IREG_ALU:   val = r0;
         seq_pkg::IREG_LEFT:  val = r1;
         seq_pkg::IREG_RIGHT: val = r2;
         default:             val = '0;
      endcase
      return val;
   endfunction

   assign op     = inst[seq_pkg::OP_MSB:seq_pkg::OP_LSB];
   assign target = inst[seq_pkg::TGT_MSB:seq_pkg::TGT_LSB];
   assign dev    = inst[seq_pkg::DEV_MSB:seq_pkg::DEV_LSB];

   assign jnz_val = read_ireg(inst[seq_pkg::JSEL_MSB:seq_pkg::JSEL_LSB],
                              ireg_0, ireg_1, ireg_2);
   assign wrr_val = read_ireg(inst[seq_pkg::RSEL_MSB:seq_pkg::RSEL_LSB],
                              ireg_0, ireg_1, ireg_2);

   assign dev_onehot = {{(seq_pkg::NUM_DEV-1){1'b0}}, 1'b1} << dev;

   // Opcode decode.
   always_comb begin
      take_jump = 1'b0;
      is_write  = 1'b0;
      word      = inst[seq_pkg::IMM_MSB:seq_pkg::IMM_LSB];
      case (op)
         seq_pkg::OP_JMP: take_jump = 1'b1;
         seq_pkg::OP_JNZ: take_jump = (jnz_val != '0);
         seq_pkg::OP_WRI: is_write = 1'b1;
         seq_pkg::OP_WRR: begin
            is_write = 1'b1;
            word     = {inst[seq_pkg::IMM_MSB:seq_pkg::HDR_LSB], wrr_val};
         end
         default: ;   // NOP and unused opcodes.
      endcase
   end

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         next     <= '0;
         oreg     <= '0;
         oreg_wen <= '0;
      end else begin
         next <= take_jump ? target : next + 1'b1;
         if (is_write) begin
            oreg     <= word;
            oreg_wen <= dev_onehot;
         end else begin
            oreg_wen <= '0;   // Enables last a single cycle.
         end
      end
   end

   // Only one peripheral takes any given word.
   a_wen_onehot: assert property (
      @(posedge clock) disable iff (!rst_n)
      $onehot0(oreg_wen)
   ) else $error("more than one write enable set: %b", oreg_wen);

endmodule

// File: source/rotary_led.sv
module rotary_led (
   input  logic       clock,
   input  logic       rst_n,
   input  logic [1:0] rotary,
   output logic [7:0] leds
);

   seq_pkg::addr_t              seq_next;
   seq_pkg::word_t              seq_oreg;
   logic [seq_pkg::NUM_DEV-1:0] seq_oreg_wen;
   seq_pkg::inst_t              rom_data;
   seq_pkg::data_t              alu_result;
   logic                        rot_left_status;
   logic                        rot_right_status;
   seq_pkg::data_t              left_reg;
   seq_pkg::data_t              right_reg;

   // Status flags read as 8-bit input registers.
   assign left_reg  = seq_pkg::data_t'(rot_left_status);
   assign right_reg = seq_pkg::data_t'(rot_right_status);

   sequencer u_sequencer (
      .clock    (clock),
      .rst_n    (rst_n),
      .inst     (rom_data),
      .ireg_0   (alu_result),
      .ireg_1   (left_reg),
      .ireg_2   (right_reg),
      .next     (seq_next),
      .oreg     (seq_oreg),
      .oreg_wen (seq_oreg_wen)
   );

   code_rom u_code_rom (
      .addr (seq_next),
      .data (rom_data)
   );

   alu u_alu (
      .clock   (clock),
      .rst_n   (rst_n),
      .inst    (seq_oreg),
      .inst_en (seq_oreg_wen[dev_pkg::DEV_ALU]),
      .result  (alu_result)
   );

   rotary_decoder u_rotary_decoder (
      .clock        (clock),
      .rst_n        (rst_n),
      .inst         (seq_oreg),
      .inst_en      (seq_oreg_wen[dev_pkg::DEV_ROT]),
      .rotary       (rotary),
      .left_status  (rot_left_status),
      .right_status (rot_right_status)
   );

   led_bank u_led_bank (
      .clock   (clock),
      .rst_n   (rst_n),
      .inst    (seq_oreg),
      .inst_en (seq_oreg_wen[dev_pkg::DEV_LED]),
      .leds    (leds)
   );

endmodule

// File: dv/rotary_led_tb.sv
module rotary_led_tb;

   localparam int NUM_ROWS   = 14;
   localparam int PHASES     = 5;
   localparam int PHASE_HOLD = 4;    // Cycles per knob phase.
   localparam int SETTLE     = 40;
   localparam int BLINK_WIN  = 64;
   localparam int STEADY_WIN = 32;
   localparam int MAX_CYCLES = NUM_ROWS * 80 + 200;

   localparam int DIR_RIGHT  = 0;
   localparam int DIR_LEFT   = 1;
   localparam int DIR_WIGGLE = 2;

   logic       clock;
   logic       rst_n;
   logic [1:0] rotary;
   logic [7:0] leds;

   int         dir_tab [NUM_ROWS];
   logic [7:0] exp_tab [NUM_ROWS];
   bit         steady_tab [NUM_ROWS];
   int         n_rows;
   int         pos;      // Left steps minus right steps, modulo 8.
   int         pass_cnt;
   int         fail_cnt;
   int         cycle_cnt;

   rotary_led u_rotary_led (
      .clock  (clock),
      .rst_n  (rst_n),
      .rotary (rotary),
      .leds   (leds)
   );

   always #10 clock = ~clock;

   always @(posedge clock) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   function automatic logic [7:0] rotate_left(input logic [7:0] val, input int n);
      logic [7:0] r;
      r = val;
      for (int k = 0; k < n; k++) begin
         r = {r[6:0], r[7]};
      end
      return r;
   endfunction

   // Knob phases as {b, a}, first phase in the top bits.
   function automatic logic [1:0] phase_value(input int dir, input int idx);
      logic [9:0] pat;
      logic [9:0] shifted;
      case (dir)
         DIR_RIGHT: pat = 10'b00_01_11_10_00;
         DIR_LEFT:  pat = 10'b00_10_11_01_00;
         default:   pat = 10'b00_10_00_10_00;   // Channel a stays low.
      endcase
      shifted = pat >> (2 * (PHASES - 1 - idx));
      return shifted[1:0];
   endfunction

   function automatic string dir_name(input int dir);
      string s;
      case (dir)
         DIR_RIGHT: s = "right step";
         DIR_LEFT:  s = "left step";
         default:   s = "b wiggle";
      endcase
      return s;
   endfunction

   task automatic add_row(input int dir, input bit steady);
      if (dir == DIR_LEFT) begin
         pos = (pos + 1) % 8;
      end else if (dir == DIR_RIGHT) begin
         pos = (pos + 7) % 8;
      end
      dir_tab[n_rows]    = dir;
      exp_tab[n_rows]    = rotate_left(8'h01, pos);
      steady_tab[n_rows] = steady;
      n_rows++;
   endtask

   task automatic record(input string name, input bit ok);
      int num;
      num = pass_cnt + fail_cnt + 1;
      if (ok) begin
         pass_cnt++;
         $display("test %0d %s: pass", num, name);
      end else begin
         fail_cnt++;
         $display("test %0d %s: fail", num, name);
      end
   endtask

   task automatic apply_step(input int dir);
      for (int p = 0; p < PHASES; p++) begin
         @(posedge clock);
         rotary <= phase_value(dir, p);
         repeat (PHASE_HOLD - 1) @(posedge clock);
      end
   endtask

   task automatic check_blink();
      bit seen_on;
      bit seen_off;
      bit bad;
      seen_on  = 1'b0;
      seen_off = 1'b0;
      bad      = 1'b0;
      for (int c = 0; c < BLINK_WIN; c++) begin
         @(negedge clock);
         assert (leds == 8'h01 || leds == 8'h00) else begin
            if (!bad) begin
               $display("error: leds = 0x%h, expected 0x01 or 0x00", leds);
            end
            bad = 1'b1;
         end
         if (leds == 8'h01) begin
            seen_on = 1'b1;
         end
         if (leds == 8'h00) begin
            seen_off = 1'b1;
         end
      end
      assert (seen_on && seen_off) else begin
         $display("leds did not blink between 0x01 and 0x00 after reset");
         bad = 1'b1;
      end
      record("blink after reset", !bad);
   endtask

   task automatic run_row(input int r);
      bit ok;
      ok = 1'b1;
      apply_step(dir_tab[r]);
      repeat (SETTLE) @(posedge clock);
      @(negedge clock);
      assert (leds == exp_tab[r]) else begin
         $display("error: leds = 0x%h, expected 0x%h", leds, exp_tab[r]);
         ok = 1'b0;
      end
      // The first detent ends the blinking for good.
      if (steady_tab[r] && ok) begin
         for (int c = 0; c < STEADY_WIN; c++) begin
            @(negedge clock);
            assert (leds == exp_tab[r]) else begin
               if (ok) begin
                  $display("error: leds = 0x%h, expected 0x%h (steady)", leds, exp_tab[r]);
               end
               ok = 1'b0;
            end
         end
      end
      record(dir_name(dir_tab[r]), ok);
   endtask

   initial begin
      clock     = 1'b0;
      rst_n     = 1'b0;
      rotary    = 2'b00;
      cycle_cnt = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      pos       = 0;
      n_rows    = 0;

      add_row(DIR_RIGHT, 1'b1);
      for (int i = 0; i < 8; i++) begin
         add_row(DIR_LEFT, 1'b0);   // Full turn back to the start.
      end
      for (int i = 0; i < 2; i++) begin
         add_row(DIR_LEFT, 1'b0);
         add_row(DIR_RIGHT, 1'b0);
      end
      add_row(DIR_WIGGLE, 1'b0);

      repeat (2) @(posedge clock);
      rst_n <= 1'b1;

      check_blink();
      for (int r = 0; r < n_rows; r++) begin
         run_row(r);
      end

      $display("passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: src.f
source/seq_pkg.sv
source/dev_pkg.sv
source/code_rom.sv
source/alu.sv
source/rotary_decoder.sv
source/led_bank.sv
source/sequencer.sv
source/rotary_led.sv
dv/rotary_led_tb.sv
